// File: execute_stage.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/inst_decoder.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/count_lead_unit.sv
hdl/execute_stage.sv
tb/tb_execute_stage.sv

// File: tb/tb_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module tb_execute_stage;

    localparam int TIMEOUT_CYCLES = 100;
    localparam logic [`EX_EXC_W-1:0] NO_EXC = '0;

    typedef struct packed {
        logic [`EX_XLEN-1:0]    inst;
        logic [`EX_XLEN-1:0]    rs;
        logic [`EX_XLEN-1:0]    rt;
        logic [`EX_XLEN-1:0]    pc;
        logic [7:0]             stall;
        logic [`EX_XLEN-1:0]    result;
        logic [`EX_REG_AW-1:0]  waddr;
        logic                   branch;
        logic [`EX_XLEN-1:0]    target;
        logic [`EX_EXC_W-1:0]   exc;
        logic                   chk_res;
        logic                   chk_tgt;
    } entry_t;

    logic                   clk;
    logic                   resetn;
    logic                   valid_i;
    logic [`EX_XLEN-1:0]    pc_i;
    ex_pkg::inst_word_t     inst_i;
    logic [`EX_XLEN-1:0]    rdata1_i;
    logic [`EX_XLEN-1:0]    rdata2_i;
    logic                   ready_i;
    logic                   done_o;
    logic                   valid_o;
    logic [`EX_XLEN-1:0]    pc_o;
    logic [`EX_XLEN-1:0]    result_o;
    logic [`EX_REG_AW-1:0]  waddr_o;
    logic                   branch_o;
    logic [`EX_XLEN-1:0]    target_pc_o;
    logic                   commit_o;
    logic [`EX_EXC_W-1:0]   commit_code_o;
    logic [`EX_XLEN-1:0]    commit_epc_o;

    entry_t                 table_q[$];
    entry_t                 cur;
    logic [`EX_XLEN-1:0]    rng;
    logic [`EX_XLEN-1:0]    seq_pc;
    int                     errors;
    int                     checks;
    int                     idx;
    int                     errs_before;
    bit                     timed_out;

    execute_stage uut (
        .clk           (clk),
        .resetn        (resetn),
        .valid_i       (valid_i),
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .rdata1_i      (rdata1_i),
        .rdata2_i      (rdata2_i),
        .ready_i       (ready_i),
        .done_o        (done_o),
        .valid_o       (valid_o),
        .pc_o          (pc_o),
        .result_o      (result_o),
        .waddr_o       (waddr_o),
        .branch_o      (branch_o),
        .target_pc_o   (target_pc_o),
        .commit_o      (commit_o),
        .commit_code_o (commit_code_o),
        .commit_epc_o  (commit_epc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`EX_XLEN-1:0] enc_r(input logic [5:0] opc, input logic [4:0] rs,
                                                  input logic [4:0] rt, input logic [4:0] rd,
                                                  input logic [4:0] sa, input logic [5:0] fn);
        return {opc, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [`EX_XLEN-1:0] enc_i(input logic [5:0] opc, input logic [4:0] rs,
                                                  input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [`EX_XLEN-1:0] enc_j(input logic [5:0] opc, input logic [25:0] idx);
        return {opc, idx};
    endfunction

    task automatic check_word(input string name, input logic [`EX_XLEN-1:0] got,
                              input logic [`EX_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`EX_REG_AW-1:0] got,
                              input logic [`EX_REG_AW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_code(input string name, input logic [`EX_EXC_W-1:0] got,
                              input logic [`EX_EXC_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic add_entry(input logic [`EX_XLEN-1:0] inst, rs, rt, pc, input int stall,
                             input logic [`EX_XLEN-1:0] result,
                             input logic [`EX_REG_AW-1:0] waddr,
                             input logic branch, input logic [`EX_XLEN-1:0] target,
                             input logic [`EX_EXC_W-1:0] exc, input logic chk_res, chk_tgt);
        entry_t e;
        e.inst    = inst;
        e.rs      = rs;
        e.rt      = rt;
        e.pc      = pc;
        e.stall   = stall[7:0];
        e.result  = result;
        e.waddr   = waddr;
        e.branch  = branch;
        e.target  = target;
        e.exc     = exc;
        e.chk_res = chk_res;
        e.chk_tgt = chk_tgt;
        table_q.push_back(e);
    endtask

    task automatic alu_entry(input logic [`EX_XLEN-1:0] inst, rs, rt, result,
                             input logic [`EX_REG_AW-1:0] waddr);
        add_entry(inst, rs, rt, seq_pc, 0, result, waddr, 1'b0, '0, NO_EXC, 1'b1, 1'b0);
        seq_pc = seq_pc + 4;
    endtask

    task automatic exc_entry(input logic [`EX_XLEN-1:0] inst, rs, rt,
                             input logic [`EX_EXC_W-1:0] code);
        add_entry(inst, rs, rt, seq_pc, 0, '0, '0, 1'b0, '0, code, 1'b0, 1'b0);
        seq_pc = seq_pc + 4;
    endtask

    task automatic branch_entry(input logic [`EX_XLEN-1:0] inst, rs, rt, pc,
                                input logic taken, input logic [`EX_XLEN-1:0] target);
        add_entry(inst, rs, rt, pc, 0, '0, '0, taken, target, NO_EXC, 1'b0, 1'b1);
    endtask

    task automatic build_table();
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic [15:0]         imm;
        seq_pc = 32'h0040_0100;
        // arithmetic and overflow cases
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 3, 0, `EX_FN_ADDU), 32'h7fff_ffff, 32'h1,
                  32'h8000_0000, 5'd3);
        exc_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 3, 0, `EX_FN_ADD), 32'h7fff_ffff, 32'h1,
                  `EX_EXC_OV);
        exc_entry(enc_i(`EX_OPC_ADDI, 1, 4, 16'h0010), 32'h7fff_fff0, 32'h0, `EX_EXC_OV);
        alu_entry(enc_i(`EX_OPC_ADDI, 1, 7, 16'hfff0), 32'h0000_0100, 32'h0, 32'h0000_00f0, 5'd7);
        alu_entry(enc_i(`EX_OPC_ADDIU, 1, 8, 16'h0010), 32'h7fff_fff0, 32'h0, 32'h8000_0000, 5'd8);
        exc_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 6, 0, `EX_FN_SUB), 32'h8000_0000, 32'h1,
                  `EX_EXC_OV);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 9, 0, `EX_FN_SUBU), 32'h5, 32'h7,
                  32'hffff_fffe, 5'd9);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 10, 0, `EX_FN_SLT), 32'hffff_ffff, 32'h1,
                  32'h1, 5'd10);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 11, 0, `EX_FN_SLTU), 32'hffff_ffff, 32'h1, 32'h0,
                  5'd11);
        alu_entry(enc_i(`EX_OPC_SLTI, 1, 12, 16'hfff8), 32'hffff_fff0, 32'h0, 32'h1, 5'd12);
        alu_entry(enc_i(`EX_OPC_SLTIU, 1, 13, 16'hffff), 32'h5, 32'h0, 32'h1, 5'd13);
        // rs value must not matter for the sa shift forms
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 14, 4, `EX_FN_SLL), 32'hffff_ffff, 32'h1234_5678,
                  32'h2345_6780, 5'd14);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 15, 8, `EX_FN_SRL), 32'hffff_ffff, 32'h8765_4321,
                  32'h0087_6543, 5'd15);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 16, 8, `EX_FN_SRA), 32'hffff_ffff, 32'h8765_4321,
                  32'hff87_6543, 5'd16);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 17, 0, `EX_FN_SLLV), 32'h24, 32'hf, 32'hf0, 5'd17);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 18, 0, `EX_FN_SRLV), 32'hffff_ffe1, 32'h8000_0000,
                  32'h4000_0000, 5'd18);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 19, 0, `EX_FN_SRAV), 32'h1f, 32'h8000_0000,
                  32'hffff_ffff, 5'd19);
        alu_entry(enc_i(`EX_OPC_LUI, 1, 20, 16'hbeef), 32'h1234_5678, 32'h0, 32'hbeef_0000, 5'd20);
        // logic ops on random operands
        rng = xorshift32(rng);
        a = rng;
        rng = xorshift32(rng);
        b = rng;
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 22, 0, `EX_FN_AND), a, b, a & b, 5'd22);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 23, 0, `EX_FN_OR), b, a, a | b, 5'd23);
        rng = xorshift32(rng);
        a = rng;
        rng = xorshift32(rng);
        b = rng;
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 24, 0, `EX_FN_XOR), a, b, a ^ b, 5'd24);
        alu_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 25, 0, `EX_FN_NOR), a, b, ~(a | b), 5'd25);
        rng = xorshift32(rng);
        a = rng;
        rng = xorshift32(rng);
        imm = rng[15:0];
        // logic immediates zero extend
        alu_entry(enc_i(`EX_OPC_ANDI, 1, 26, imm), a, 32'h0, a & {16'h0, imm}, 5'd26);
        alu_entry(enc_i(`EX_OPC_ORI, 1, 27, imm), a, 32'h0, a | {16'h0, imm}, 5'd27);
        alu_entry(enc_i(`EX_OPC_XORI, 1, 28, imm), a, 32'h0, a ^ {16'h0, imm}, 5'd28);
        add_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 5, 0, `EX_FN_SUBU), 32'd10, 32'd3, 32'h0040_0400, 3,
                  32'd7, 5'd5, 1'b0, '0, NO_EXC, 1'b1, 1'b0);
        // reserved encodings
        exc_entry(enc_i(6'h3f, 1, 2, 16'h1234), 32'h0, 32'h0, `EX_EXC_RI);
        exc_entry(enc_r(`EX_OPC_SPECIAL, 1, 2, 3, 0, 6'h0d), 32'h0, 32'h0, `EX_EXC_RI);
        exc_entry(enc_i(`EX_OPC_REGIMM, 1, 5'h11, 16'h0004), 32'h0, 32'h0, `EX_EXC_RI);
        // branches from 0x00401000 with pc+4 at 0x00401004
        branch_entry(enc_i(`EX_OPC_BEQ, 1, 2, 16'h0010), 32'h55, 32'h55, 32'h0040_1000, 1'b1,
                     32'h0040_1044);
        branch_entry(enc_i(`EX_OPC_BEQ, 1, 2, 16'h0010), 32'h1, 32'h2, 32'h0040_1000, 1'b0,
                     32'h0040_1044);
        branch_entry(enc_i(`EX_OPC_BNE, 1, 2, 16'hfffc), 32'h1, 32'h2, 32'h0040_1000, 1'b1,
                     32'h0040_0ff4);
        branch_entry(enc_i(`EX_OPC_BLEZ, 1, 0, 16'h0001), 32'h0, 32'h0, 32'h0040_1000, 1'b1,
                     32'h0040_1008);
        branch_entry(enc_i(`EX_OPC_BGTZ, 1, 0, 16'h0002), 32'h8000_0000, 32'h0, 32'h0040_1000,
                     1'b0, 32'h0040_100c);
        branch_entry(enc_i(`EX_OPC_BGTZ, 1, 0, 16'h0002), 32'h5, 32'h0, 32'h0040_1000, 1'b1,
                     32'h0040_100c);
        branch_entry(enc_i(`EX_OPC_REGIMM, 1, `EX_RT_BLTZ, 16'h0003), 32'hffff_ffff, 32'h0,
                     32'h0040_1000, 1'b1, 32'h0040_1010);
        branch_entry(enc_i(`EX_OPC_REGIMM, 1, `EX_RT_BGEZ, 16'h0003), 32'hffff_ffff, 32'h0,
                     32'h0040_1000, 1'b0, 32'h0040_1010);
        branch_entry(enc_i(`EX_OPC_REGIMM, 1, `EX_RT_BGEZ, 16'h0003), 32'h0, 32'h0,
                     32'h0040_1000, 1'b1, 32'h0040_1010);
        branch_entry(enc_j(`EX_OPC_J, 26'h012_3456), 32'h0, 32'h0, 32'hbfc0_0000, 1'b1,
                     32'hb048_d158);
        branch_entry(enc_r(`EX_OPC_SPECIAL, 31, 0, 0, 0, `EX_FN_JR), 32'h8000_1234, 32'h0,
                     32'h0040_1000, 1'b1, 32'h8000_1234);
        add_entry(enc_j(`EX_OPC_JAL, 26'h010_0040), 32'h0, 32'h0, 32'h0040_2000, 0,
                  32'h0040_2008, 5'd31, 1'b1, 32'h0040_0100, NO_EXC, 1'b1, 1'b1);
        // leading zero and one counts
        alu_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 21, 0, `EX_FN_CLZ), 32'h0, 32'h0, 32'd32, 5'd21);
        alu_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 21, 0, `EX_FN_CLO), 32'hffff_ffff, 32'h0, 32'd32,
                  5'd21);
        alu_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 22, 0, `EX_FN_CLZ), 32'hffff_ffff, 32'h0, 32'd0,
                  5'd22);
        alu_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 23, 0, `EX_FN_CLZ), 32'h4000_0000, 32'h0, 32'd1,
                  5'd23);
        alu_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 24, 0, `EX_FN_CLO), 32'hf800_1234, 32'h0, 32'd5,
                  5'd24);
        alu_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 25, 0, `EX_FN_CLZ), 32'h0000_0001, 32'h0, 32'd31,
                  5'd25);
        alu_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 26, 0, `EX_FN_CLO), 32'hffff_fffe, 32'h0, 32'd31,
                  5'd26);
        // clo held under back-pressure
        add_entry(enc_r(`EX_OPC_SPECIAL2, 1, 0, 30, 0, `EX_FN_CLO), 32'hfc00_0000, 32'h0,
                  32'h0040_0800, 5, 32'd6, 5'd30, 1'b0, '0, NO_EXC, 1'b1, 1'b0);
    endtask

    task automatic run_entry(input entry_t e);
        int   waited;
        int   k;
        logic held_valid;
        @(posedge clk);
        #2;
        valid_i  = 1'b1;
        pc_i     = e.pc;
        inst_i   = e.inst;
        rdata1_i = e.rs;
        rdata2_i = e.rt;
        ready_i  = 1'b0;
        waited   = 0;
        @(negedge clk);
        while (!done_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!done_o) begin
            timed_out = 1'b1;
            $display("done_o did not rise within %0d cycles", TIMEOUT_CYCLES);
        end else begin
            held_valid = valid_o;
            check_bit("commit_o", commit_o, e.exc != NO_EXC);
            if (e.exc != NO_EXC) begin
                check_code("commit_code_o", commit_code_o, e.exc);
                check_word("commit_epc_o", commit_epc_o, e.pc);
            end
            check_bit("branch_o", branch_o, e.branch);
            if (e.chk_tgt) begin
                check_word("target_pc_o", target_pc_o, e.target);
            end
            for (k = 0; k < e.stall; k++) begin
                @(posedge clk);
                @(negedge clk);
                check_bit("done_o", done_o, 1'b1);
                check_bit("valid_o", valid_o, held_valid);
            end
            @(posedge clk);
            #2;
            ready_i = 1'b1;
            @(posedge clk);
            #2;
            valid_i = 1'b0;
            ready_i = 1'b0;
            check_bit("valid_o", valid_o, e.exc == NO_EXC);
            if (e.exc == NO_EXC) begin
                check_word("pc_o", pc_o, e.pc);
                check_addr("waddr_o", waddr_o, e.waddr);
                if (e.chk_res) begin
                    check_word("result_o", result_o, e.result);
                end
            end
        end
    endtask

    initial begin
        resetn    = 1'b0;
        valid_i   = 1'b0;
        pc_i      = '0;
        // idle jump and reserved words must not raise branch_o or commit_o
        inst_i    = enc_j(`EX_OPC_J, 26'h0);
        rdata1_i  = '0;
        rdata2_i  = '0;
        ready_i   = 1'b0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        rng       = 32'h4435a6e5;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        resetn = 1'b1;
        @(negedge clk);
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("branch_o", branch_o, 1'b0);
        @(posedge clk);
        #2;
        inst_i = enc_i(6'h3f, 0, 0, 16'h0);
        @(negedge clk);
        check_bit("commit_o", commit_o, 1'b0);
        idx = 0;
        while (idx < table_q.size() && !timed_out) begin
            cur = table_q[idx];
            errs_before = errors;
            run_entry(cur);
            if (timed_out) begin
                $display("entry %0d inst %h did not complete", idx, cur.inst);
            end else if (errors == errs_before) begin
                $display("entry %0d inst %h ok", idx, cur.inst);
            end else begin
                $display("entry %0d inst %h had %0d errors", idx, cur.inst, errors - errs_before);
            end
            idx++;
        end
        $display("%0d entries, %0d checks, %0d errors", idx, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module execute_stage (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         valid_i,
    input  wire [`EX_XLEN-1:0]          pc_i,
    input  wire ex_pkg::inst_word_t     inst_i,
    input  wire [`EX_XLEN-1:0]          rdata1_i,
    input  wire [`EX_XLEN-1:0]          rdata2_i,
    input  wire                         ready_i,
    output logic                        done_o,
    output logic                        valid_o,
    output logic [`EX_XLEN-1:0]         pc_o,
    output logic [`EX_XLEN-1:0]         result_o,
    output logic [`EX_REG_AW-1:0]       waddr_o,
    output logic                        branch_o,
    output logic [`EX_XLEN-1:0]         target_pc_o,
    output logic                        commit_o,
    output logic [`EX_EXC_W-1:0]        commit_code_o,
    output logic [`EX_XLEN-1:0]         commit_epc_o
);

    logic [`EX_ALU_OPW-1:0] alu_op;
    logic                   alu_a_sa, alu_b_imm, imm_sx, ov_check;
    logic                   is_branch, is_link, is_cloz, is_clo, is_lui, reserved;
    logic [`EX_REG_AW-1:0]  dec_waddr;
    logic [`EX_XLEN-1:0]    imm32, alu_a, alu_b, alu_result, result;
    logic                   alu_ov, ov_exc, exc;
    logic                   cz_busy, cz_ready;
    logic [5:0]             cz_count;
    logic                   done;
    logic                   valid;

    // a held instruction is not launched twice
    assign valid = valid_i && !done;

    inst_decoder u_dec (
        .inst_i      (inst_i),
        .alu_op_o    (alu_op),
        .alu_a_sa_o  (alu_a_sa),
        .alu_b_imm_o (alu_b_imm),
        .imm_sx_o    (imm_sx),
        .ov_check_o  (ov_check),
        .is_branch_o (is_branch),
        .is_link_o   (is_link),
        .is_cloz_o   (is_cloz),
        .is_clo_o    (is_clo),
        .is_lui_o    (is_lui),
        .reserved_o  (reserved),
        .waddr_o     (dec_waddr)
    );

    assign imm32 = imm_sx ? {{(`EX_XLEN-`EX_IMM_W){inst_i.i.imm[`EX_IMM_W-1]}}, inst_i.i.imm}
                          : {{(`EX_XLEN-`EX_IMM_W){1'b0}}, inst_i.i.imm};
    assign alu_a = alu_a_sa ? {{(`EX_XLEN-`EX_REG_AW){1'b0}}, inst_i.r.sa} : rdata1_i;
    assign alu_b = alu_b_imm ? imm32 : rdata2_i;

    int_alu u_alu (
        .a_i        (alu_a),
        .b_i        (alu_b),
        .op_i       (alu_op),
        .result_o   (alu_result),
        .overflow_o (alu_ov)
    );

    branch_unit u_br (
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs_i        (rdata1_i),
        .rt_i        (rdata2_i),
        .valid_i     (valid_i && is_branch),
        .branch_o    (branch_o),
        .target_pc_o (target_pc_o)
    );

    count_lead_unit u_clz (
        .clk       (clk),
        .resetn    (resetn),
        .start_i   (valid && is_cloz && !cz_busy),
        .is_clo_i  (is_clo),
        .data_i    (rdata1_i),
        .release_i (done_o && ready_i),
        .busy_o    (cz_busy),
        .ready_o   (cz_ready),
        .count_o   (cz_count)
    );

    always_comb begin
        if (is_cloz) begin
            result = {{(`EX_XLEN-6){1'b0}}, cz_count};
        end else if (is_lui) begin
            result = {inst_i.i.imm, {`EX_IMM_W{1'b0}}};
        end else if (is_link) begin
            result = pc_i + `EX_XLEN'd8;
        end else begin
            result = alu_result;
        end
    end

    // exceptions
    assign ov_exc        = ov_check && alu_ov;
    assign exc           = reserved || ov_exc;
    assign commit_o      = valid && exc;
    assign commit_code_o = reserved ? `EX_EXC_RI : `EX_EXC_OV;
    assign commit_epc_o  = pc_i;

    // only clz/clo take more than one cycle
    assign done_o = exc || !is_cloz || cz_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else if (ready_i) begin
            done <= 1'b0;
        end else if (valid_i && done_o) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_o <= 1'b0;
        end else if (ready_i) begin
            valid_o <= valid_i && done_o && !exc;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_i) begin
            pc_o     <= pc_i;
            result_o <= result;
            waddr_o  <= dec_waddr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/count_lead_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module count_lead_unit (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     start_i,
    input  wire                     is_clo_i,
    input  wire [`EX_XLEN-1:0]      data_i,
    input  wire                     release_i,
    output logic                    busy_o,
    output logic                    ready_o,
    output logic [5:0]              count_o
);

    logic                busy_q;
    logic [`EX_XLEN-1:0] shift_q;
    logic [5:0]          cnt_q;
    logic                all_counted;

    assign all_counted = cnt_q == 6'(`EX_XLEN);

    // stop at first zero on top, or after a full word
    assign ready_o = busy_q && (!shift_q[`EX_XLEN-1] || all_counted);
    assign busy_o  = busy_q;
    assign count_o = cnt_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
        end else if (release_i) begin
            busy_q <= 1'b0;
        end
    end

    // clz works on the inverted word, so both count ones
    always_ff @(posedge clk) begin
        if (start_i) begin
            shift_q <= is_clo_i ? data_i : ~data_i;
            cnt_q   <= '0;
        end else if (busy_q && !ready_o) begin
            shift_q <= shift_q << 1;
            cnt_q   <= cnt_q + 6'd1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module branch_unit (
    input  wire ex_pkg::inst_word_t     inst_i,
    input  wire [`EX_XLEN-1:0]          pc_i,
    input  wire [`EX_XLEN-1:0]          rs_i,
    input  wire [`EX_XLEN-1:0]          rt_i,
    input  wire                         valid_i,
    output logic                        branch_o,
    output logic [`EX_XLEN-1:0]         target_pc_o
);

    logic [`EX_XLEN-1:0] pc_plus4;
    logic [`EX_XLEN-1:0] br_target;
    logic [`EX_XLEN-1:0] j_target;
    logic                rs_neg;
    logic                rs_zero;
    logic                taken;
    logic                is_j;
    logic                is_jr;

    assign pc_plus4  = pc_i + `EX_XLEN'd4;
    assign br_target = pc_plus4 + {{(`EX_XLEN-18){inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
    // jump index is rs:rt:imm
    assign j_target  = {pc_plus4[`EX_XLEN-1:28], inst_i.i.rs, inst_i.i.rt, inst_i.i.imm, 2'b00};

    assign rs_neg  = rs_i[`EX_XLEN-1];
    assign rs_zero = rs_i == '0;

    always_comb begin
        taken = 1'b0;
        is_j  = 1'b0;
        is_jr = 1'b0;
        case (inst_i.i.opcode)
            `EX_OPC_BEQ:     taken = rs_i == rt_i;
            `EX_OPC_BNE:     taken = rs_i != rt_i;
            `EX_OPC_BLEZ:    taken = rs_neg || rs_zero;
            `EX_OPC_BGTZ:    taken = !rs_neg && !rs_zero;
            `EX_OPC_REGIMM:  taken = (inst_i.i.rt == `EX_RT_BLTZ) ? rs_neg
                                   : (inst_i.i.rt == `EX_RT_BGEZ) && !rs_neg;
            `EX_OPC_J,
            `EX_OPC_JAL:     is_j = 1'b1;
            `EX_OPC_SPECIAL: is_jr = inst_i.r.funct == `EX_FN_JR;
            default:         taken = 1'b0;
        endcase
    end

    assign branch_o    = valid_i && (taken || is_j || is_jr);
    assign target_pc_o = is_jr ? rs_i : (is_j ? j_target : br_target);

endmodule

`default_nettype wire

// File: hdl/int_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module int_alu (
    input  wire [`EX_XLEN-1:0]      a_i,
    input  wire [`EX_XLEN-1:0]      b_i,
    input  wire [`EX_ALU_OPW-1:0]   op_i,
    output logic [`EX_XLEN-1:0]     result_o,
    output logic                    overflow_o
);

    localparam int MSB = `EX_XLEN - 1;

    logic [`EX_XLEN-1:0] sum;
    logic [`EX_XLEN-1:0] diff;
    logic [4:0]          shamt;
    logic                add_ov;
    logic                sub_ov;

    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    assign shamt = a_i[4:0];

    // signed overflow: operand signs vs result sign
    assign add_ov = (a_i[MSB] == b_i[MSB]) && (sum[MSB] != a_i[MSB]);
    assign sub_ov = (a_i[MSB] != b_i[MSB]) && (diff[MSB] != a_i[MSB]);

    always_comb begin
        overflow_o = 1'b0;
        case (op_i)
            `EX_ALU_ADD: begin
                result_o   = sum;
                overflow_o = add_ov;
            end
            `EX_ALU_SUB: begin
                result_o   = diff;
                overflow_o = sub_ov;
            end
            `EX_ALU_AND:  result_o = a_i & b_i;
            `EX_ALU_OR:   result_o = a_i | b_i;
            `EX_ALU_XOR:  result_o = a_i ^ b_i;
            `EX_ALU_NOR:  result_o = ~(a_i | b_i);
            `EX_ALU_SLT: begin
                result_o = {{MSB{1'b0}}, $signed(a_i) < $signed(b_i)};
            end
            `EX_ALU_SLTU: begin
                result_o = {{MSB{1'b0}}, a_i < b_i};
            end
            // shifts move b by the amount in a
            `EX_ALU_SLL:  result_o = b_i << shamt;
            `EX_ALU_SRL:  result_o = b_i >> shamt;
            `EX_ALU_SRA:  result_o = $signed(b_i) >>> shamt;
            default:      result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module inst_decoder (
    input  wire ex_pkg::inst_word_t     inst_i,
    output logic [`EX_ALU_OPW-1:0]      alu_op_o,
    output logic                        alu_a_sa_o,
    output logic                        alu_b_imm_o,
    output logic                        imm_sx_o,
    output logic                        ov_check_o,
    output logic                        is_branch_o,
    output logic                        is_link_o,
    output logic                        is_cloz_o,
    output logic                        is_clo_o,
    output logic                        is_lui_o,
    output logic                        reserved_o,
    output logic [`EX_REG_AW-1:0]       waddr_o
);

    always_comb begin
        alu_op_o    = `EX_ALU_ADD;
        alu_a_sa_o  = 1'b0;
        alu_b_imm_o = 1'b0;
        imm_sx_o    = 1'b1;
        ov_check_o  = 1'b0;
        is_branch_o = 1'b0;
        is_link_o   = 1'b0;
        is_cloz_o   = 1'b0;
        is_clo_o    = 1'b0;
        is_lui_o    = 1'b0;
        reserved_o  = 1'b0;
        waddr_o     = '0;

        case (inst_i.r.opcode)
            `EX_OPC_SPECIAL: begin
                waddr_o = inst_i.r.rd;
                case (inst_i.r.funct)
                    `EX_FN_SLL:  begin alu_op_o = `EX_ALU_SLL; alu_a_sa_o = 1'b1; end
                    `EX_FN_SRL:  begin alu_op_o = `EX_ALU_SRL; alu_a_sa_o = 1'b1; end
                    `EX_FN_SRA:  begin alu_op_o = `EX_ALU_SRA; alu_a_sa_o = 1'b1; end
                    `EX_FN_SLLV: alu_op_o = `EX_ALU_SLL;
                    `EX_FN_SRLV: alu_op_o = `EX_ALU_SRL;
                    `EX_FN_SRAV: alu_op_o = `EX_ALU_SRA;
                    `EX_FN_ADD:  ov_check_o = 1'b1;
                    `EX_FN_ADDU: alu_op_o = `EX_ALU_ADD;
                    `EX_FN_SUB:  begin alu_op_o = `EX_ALU_SUB; ov_check_o = 1'b1; end
                    `EX_FN_SUBU: alu_op_o = `EX_ALU_SUB;
                    `EX_FN_AND:  alu_op_o = `EX_ALU_AND;
                    `EX_FN_OR:   alu_op_o = `EX_ALU_OR;
                    `EX_FN_XOR:  alu_op_o = `EX_ALU_XOR;
                    `EX_FN_NOR:  alu_op_o = `EX_ALU_NOR;
                    `EX_FN_SLT:  alu_op_o = `EX_ALU_SLT;
                    `EX_FN_SLTU: alu_op_o = `EX_ALU_SLTU;
                    `EX_FN_JR:   begin is_branch_o = 1'b1; waddr_o = '0; end
                    default:     begin reserved_o = 1'b1; waddr_o = '0; end
                endcase
            end
            `EX_OPC_REGIMM: begin
                // only bltz and bgez kept
                if (inst_i.i.rt == `EX_RT_BLTZ || inst_i.i.rt == `EX_RT_BGEZ) begin
                    is_branch_o = 1'b1;
                end else begin
                    reserved_o = 1'b1;
                end
            end
            `EX_OPC_SPECIAL2: begin
                if (inst_i.r.funct == `EX_FN_CLZ || inst_i.r.funct == `EX_FN_CLO) begin
                    is_cloz_o = 1'b1;
                    is_clo_o  = inst_i.r.funct == `EX_FN_CLO;
                    waddr_o   = inst_i.r.rd;
                end else begin
                    reserved_o = 1'b1;
                end
            end
            `EX_OPC_J, `EX_OPC_BEQ, `EX_OPC_BNE, `EX_OPC_BLEZ, `EX_OPC_BGTZ: begin
                is_branch_o = 1'b1;
            end
            `EX_OPC_JAL: begin
                is_branch_o = 1'b1;
                is_link_o   = 1'b1;
                waddr_o     = `EX_LINK_REG;
            end
            `EX_OPC_ADDI: begin
                alu_b_imm_o = 1'b1;
                ov_check_o  = 1'b1;
                waddr_o     = inst_i.i.rt;
            end
            `EX_OPC_ADDIU: begin
                alu_b_imm_o = 1'b1;
                waddr_o     = inst_i.i.rt;
            end
            `EX_OPC_SLTI, `EX_OPC_SLTIU: begin
                alu_op_o    = (inst_i.i.opcode == `EX_OPC_SLTI) ? `EX_ALU_SLT : `EX_ALU_SLTU;
                alu_b_imm_o = 1'b1;
                waddr_o     = inst_i.i.rt;
            end
            `EX_OPC_ANDI, `EX_OPC_ORI, `EX_OPC_XORI: begin
                // logic immediates are zero extended
                case (inst_i.i.opcode)
                    `EX_OPC_ANDI: alu_op_o = `EX_ALU_AND;
                    `EX_OPC_ORI:  alu_op_o = `EX_ALU_OR;
                    default:      alu_op_o = `EX_ALU_XOR;
                endcase
                alu_b_imm_o = 1'b1;
                imm_sx_o    = 1'b0;
                waddr_o     = inst_i.i.rt;
            end
            `EX_OPC_LUI: begin
                is_lui_o = 1'b1;
                waddr_o  = inst_i.i.rt;
            end
            default: reserved_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/ex_pkg.sv
`default_nettype none
`include "ex_params.svh"

package ex_pkg;

    // register form
    typedef struct packed {
        logic [`EX_OPC_W-1:0]   opcode;
        logic [`EX_REG_AW-1:0]  rs;
        logic [`EX_REG_AW-1:0]  rt;
        logic [`EX_REG_AW-1:0]  rd;
        logic [`EX_REG_AW-1:0]  sa;
        logic [`EX_OPC_W-1:0]   funct;
    } r_form_t;

    // immediate form, also carries the jump index in rs:rt:imm
    typedef struct packed {
        logic [`EX_OPC_W-1:0]   opcode;
        logic [`EX_REG_AW-1:0]  rs;
        logic [`EX_REG_AW-1:0]  rt;
        logic [`EX_IMM_W-1:0]   imm;
    } i_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
    } inst_word_t;

endpackage

`default_nettype wire

// File: hdl/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// widths
`define EX_XLEN         32
`define EX_REG_AW       5
`define EX_OPC_W        6
`define EX_IMM_W        16
`define EX_ALU_OPW      4
`define EX_EXC_W        5

// alu operations
`define EX_ALU_ADD      4'd0
`define EX_ALU_SUB      4'd1
`define EX_ALU_AND      4'd2
`define EX_ALU_OR       4'd3
`define EX_ALU_XOR      4'd4
`define EX_ALU_NOR      4'd5
`define EX_ALU_SLT      4'd6
`define EX_ALU_SLTU     4'd7
`define EX_ALU_SLL      4'd8
`define EX_ALU_SRL      4'd9
`define EX_ALU_SRA      4'd10

// major opcodes
`define EX_OPC_SPECIAL  6'b000000
`define EX_OPC_REGIMM   6'b000001
`define EX_OPC_J        6'b000010
`define EX_OPC_JAL      6'b000011
`define EX_OPC_BEQ      6'b000100
`define EX_OPC_BNE      6'b000101
`define EX_OPC_BLEZ     6'b000110
`define EX_OPC_BGTZ     6'b000111
`define EX_OPC_ADDI     6'b001000
`define EX_OPC_ADDIU    6'b001001
`define EX_OPC_SLTI     6'b001010
`define EX_OPC_SLTIU    6'b001011
`define EX_OPC_ANDI     6'b001100
`define EX_OPC_ORI      6'b001101
`define EX_OPC_XORI     6'b001110
`define EX_OPC_LUI      6'b001111
`define EX_OPC_SPECIAL2 6'b011100

// SPECIAL function codes
`define EX_FN_SLL       6'b000000
`define EX_FN_SRL       6'b000010
`define EX_FN_SRA       6'b000011
`define EX_FN_SLLV      6'b000100
`define EX_FN_SRLV      6'b000110
`define EX_FN_SRAV      6'b000111
`define EX_FN_JR        6'b001000
`define EX_FN_ADD       6'b100000
`define EX_FN_ADDU      6'b100001
`define EX_FN_SUB       6'b100010
`define EX_FN_SUBU      6'b100011
`define EX_FN_AND       6'b100100
`define EX_FN_OR        6'b100101
`define EX_FN_XOR       6'b100110
`define EX_FN_NOR       6'b100111
`define EX_FN_SLT       6'b101010
`define EX_FN_SLTU      6'b101011

// SPECIAL2 function codes
`define EX_FN_CLZ       6'b100000
`define EX_FN_CLO       6'b100001

// REGIMM rt codes
`define EX_RT_BLTZ      5'b00000
`define EX_RT_BGEZ      5'b00001

// exception codes
`define EX_EXC_RI       5'h0a
`define EX_EXC_OV       5'h0c

`define EX_LINK_REG     5'd31

`endif
